//--- verilog/picc_pkg.sv
// shared definitions for the ISO 14443-3 type A init responder
// command and reply codes, buffer sizes, UID types
// card state and reply opcode enums

package picc_pkg;

    // ==============================
    // sizes
    // ==============================

    // double size UID, two cascade levels
    localparam int uid_bytes_c = 7;

    // SELECT is the longest command: SEL, NVB, 4 UID bytes, BCC
    localparam int rx_buf_len_c = 7;

    // longest reply is AC with NVB 0x20: 4 UID bytes plus BCC
    localparam int tx_buf_len_c = 5;

    // ==============================
    // UID types
    // ==============================

    typedef logic [uid_bytes_c*8-1:0] uid_t;

    // one cascade level as sent on air
    // uid[7:0] goes first, bcc last
    typedef struct packed {
        logic [7:0]  bcc;
        logic [31:0] uid;
    } cascade_data_t;

    // ==============================
    // command and reply codes
    // ==============================

    // short frames, 7 bits
    localparam logic [6:0] cmd_reqa_c = 7'h26;
    localparam logic [6:0] cmd_wupa_c = 7'h52;

    // HLTA is 0x50 then 0x00, low byte received first
    localparam logic [15:0] cmd_hlta_c = 16'h0050;

    // select codes per cascade level
    localparam logic [7:0] sel_cl1_c = 8'h93;
    localparam logic [7:0] sel_cl2_c = 8'h95;

    // tells the reader that more UID follows in the next level
    localparam logic [7:0] cascade_tag_c = 8'h88;

    // bits 7:6 = 01 for double size, bit 2 for bit frame anticollision
    localparam logic [15:0] atqa_double_c = 16'h0044;

    // bit 2 set means UID not complete yet
    localparam logic [7:0] sak_complete_c     = 8'h00;
    localparam logic [7:0] sak_not_complete_c = 8'h04;

    // ==============================
    // enums
    // ==============================

    // the HALT variants are idle/ready/active plus a separate star flag
    typedef enum logic [1:0] {
        state_idle,
        state_ready,
        state_active
    } picc_state_e;

    typedef enum logic [1:0] {
        reply_none,
        reply_atqa,
        reply_ac,
        reply_sak
    } reply_e;

endpackage

//--- verilog/rx_frame_if.sv
// captured command frame, input side to the card state machine
// the state machine returns the expected cascade bytes and select code

`timescale 1ns/1ps

interface rx_frame_if
    import picc_pkg::cascade_data_t;
();

    // from the frame capture
    logic          pkt_received;
    logic          frame_error;
    logic [7:0]    first_byte;
    logic [7:0]    second_byte;
    // upper and lower nibble of the NVB byte
    logic [3:0]    nvb_bytes;
    logic [3:0]    nvb_bits;
    logic          uid_match;

    // from the state machine, current cascade level
    cascade_data_t expected;
    logic [7:0]    sel_code;

    modport producer (
        output pkt_received, frame_error, first_byte, second_byte,
        output nvb_bytes, nvb_bits, uid_match,
        input  expected, sel_code
    );

    modport consumer (
        input  pkt_received, frame_error, first_byte, second_byte,
        input  nvb_bytes, nvb_bits, uid_match,
        output expected, sel_code
    );

endinterface

//--- verilog/reply_if.sv
// reply request from the card state machine to the reply buffer

`timescale 1ns/1ps

interface reply_if
    import picc_pkg::reply_e, picc_pkg::cascade_data_t;
();

    // non-none for one cycle per reply
    reply_e        reply;

    // UID bytes and BCC of the current cascade level
    cascade_data_t cascade_data;

    // UID bytes the reader already sent in the AC frame
    logic [2:0]    skip_bytes;

    // current level is the last one, selects the SAK value
    logic          uid_complete;

    modport source (
        output reply, cascade_data, skip_bytes, uid_complete
    );

    modport sink (
        input  reply, cascade_data, skip_bytes, uid_complete
    );

endinterface

//--- verilog/rx_frame_buffer.sv
// command frame capture
// keeps the command and NVB bytes, counts bytes, latches rx errors
// compares received UID bytes against the current cascade level

`timescale 1ns/1ps

module rx_frame_buffer
    import picc_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    input  logic         rx_soc,
    input  logic         rx_eoc,
    input  logic         rx_error,
    input  logic         rx_data_valid,
    input  logic [7:0]   rx_data,

    rx_frame_if.producer frame
);

    // byte 0 is the command or select code, byte 1 the NVB
    logic [7:0] cmd_byte;
    logic [7:0] nvb_byte;

    // counts up to rx_buf_len_c, later bytes (CRC) are not looked at
    logic [2:0] byte_cnt;
    logic       err_q;
    logic       match_q;
    logic       pkt_q;

    // expected on-air byte for the current position
    logic [7:0] expected_byte;

    // ==============================
    // expected UID byte
    // ==============================

    always_comb begin
        case (byte_cnt)
            // positions 0 and 1 are SEL and NVB, never compared
            3'd2:    expected_byte = frame.expected.uid[7:0];
            3'd3:    expected_byte = frame.expected.uid[15:8];
            3'd4:    expected_byte = frame.expected.uid[23:16];
            3'd5:    expected_byte = frame.expected.uid[31:24];
            default: expected_byte = frame.expected.bcc;
        endcase
    end

    // ==============================
    // capture
    // ==============================

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt <= '0;
            err_q    <= 1'b0;
            match_q  <= 1'b0;
            pkt_q    <= 1'b0;
        end
        else begin
            // frame done one cycle after eoc, so the last byte is already stored
            pkt_q <= rx_eoc;

            // new frame, assume it addresses us until a byte differs
            if (rx_soc) begin
                byte_cnt <= '0;
                err_q    <= 1'b0;
                match_q  <= 1'b1;
            end

            // sticky until the next soc
            if (rx_error) begin
                err_q <= 1'b1;
            end

            if (rx_data_valid && (byte_cnt != 3'(rx_buf_len_c))) begin
                byte_cnt <= byte_cnt + 3'd1;
                // UID and BCC bytes
                if ((byte_cnt >= 3'd2) && (rx_data != expected_byte)) begin
                    match_q <= 1'b0;
                end
            end
        end
    end

    // header bytes, payload only
    always_ff @(posedge clk) begin
        if (rx_data_valid) begin
            if (byte_cnt == 3'd0) begin
                cmd_byte <= rx_data;
            end
            if (byte_cnt == 3'd1) begin
                nvb_byte <= rx_data;
            end
        end
    end

    // ==============================
    // outputs
    // ==============================

    assign frame.pkt_received = pkt_q;
    assign frame.frame_error  = err_q;
    assign frame.first_byte   = cmd_byte;
    assign frame.second_byte  = nvb_byte;
    assign frame.nvb_bytes    = nvb_byte[7:4];
    assign frame.nvb_bits     = nvb_byte[3:0];

    // UID bytes matched and the frame is for the current cascade level
    assign frame.uid_match = match_q && (cmd_byte == frame.sel_code);

endmodule

//--- verilog/picc_state_fsm.sv
// card state machine for ISO 14443-3 type A initialisation
// idle / ready / active plus the halt star flag
// cascade level register, cascade UID and BCC, reply selection

`timescale 1ns/1ps

module picc_state_fsm
    import picc_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    input  uid_t         uid,
    // valid while pkt_received is high
    input  logic         rx_crc_ok,

    rx_frame_if.consumer frame,
    reply_if.source      rep
);

    picc_state_e   state;
    picc_state_e   next_state;
    logic          star;
    logic          next_star;
    // 1 or 2
    logic [1:0]    cascade_level;
    logic [1:0]    next_level;

    cascade_data_t level_data;
    logic          final_level;
    reply_e        reply;

    logic          is_reqa;
    logic          is_wupa;
    logic          is_hlta;
    logic          is_ac;
    logic          is_select;

    // ==============================
    // cascade data
    // ==============================

    // level 1 carries the tag and UID0..2, level 2 carries UID3..6
    assign final_level    = (cascade_level == 2'd2);
    assign level_data.uid = final_level ? uid[55:24] : {uid[23:0], cascade_tag_c};
    assign level_data.bcc = level_data.uid[31:24] ^ level_data.uid[23:16] ^
                            level_data.uid[15:8]  ^ level_data.uid[7:0];

    // back to the capture side for the byte compare
    assign frame.expected = level_data;
    assign frame.sel_code = final_level ? sel_cl2_c : sel_cl1_c;

    // ==============================
    // command decode
    // ==============================

    // short frames only carry 7 bits, ignore bit 7
    assign is_reqa = (frame.first_byte[6:0] == cmd_reqa_c);
    assign is_wupa = (frame.first_byte[6:0] == cmd_wupa_c);
    assign is_hlta = ({frame.second_byte, frame.first_byte} == cmd_hlta_c) && rx_crc_ok;

    // whole bytes only, a partial bit count never matches
    assign is_select = frame.uid_match && (frame.nvb_bytes == 4'd7) &&
                       (frame.nvb_bits == 4'd0);
    assign is_ac     = frame.uid_match && (frame.nvb_bits == 4'd0) &&
                       (frame.nvb_bytes >= 4'd2) && (frame.nvb_bytes <= 4'd6);

    // ==============================
    // state registers
    // ==============================

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state         <= state_idle;
            star          <= 1'b0;
            cascade_level <= 2'd1;
        end
        else begin
            state         <= next_state;
            star          <= next_star;
            cascade_level <= next_level;
        end
    end

    always_comb begin
        next_state = state;
        next_star  = star;
        next_level = cascade_level;
        reply      = reply_none;

        if (frame.pkt_received) begin
            if (frame.frame_error) begin
                // broken frame drops us out of ready/active, star kept
                if (state != state_idle) begin
                    next_state = state_idle;
                end
            end
            else begin
                case (state)
                    state_idle: begin
                        // halted card only wakes on WUPA
                        if ((is_reqa && !star) || is_wupa) begin
                            next_state = state_ready;
                            next_level = 2'd1;
                            reply      = reply_atqa;
                        end
                    end
                    state_ready: begin
                        if (is_select && rx_crc_ok) begin
                            reply = reply_sak;
                            if (final_level) begin
                                next_state = state_active;
                            end
                            else begin
                                next_level = 2'd2;
                            end
                        end
                        else if (is_ac) begin
                            reply = reply_ac;
                        end
                        else begin
                            // includes SELECT with bad CRC
                            next_state = state_idle;
                        end
                    end
                    state_active: begin
                        next_state = state_idle;
                        if (is_hlta) begin
                            next_star = 1'b1;
                        end
                    end
                    default: begin
                        next_state = state_idle;
                    end
                endcase
            end
        end
    end

    // ==============================
    // reply request
    // ==============================

    assign rep.reply        = reply;
    assign rep.cascade_data = level_data;
    assign rep.skip_bytes   = 3'(frame.nvb_bytes - 4'd2);
    assign rep.uid_complete = final_level;

endmodule

//--- verilog/reply_tx_buffer.sv
// reply buffer towards the transmitter
// loads ATQA, SAK or cascade bytes, drops the bytes the reader
// already sent, then hands out one byte per tx_req

`timescale 1ns/1ps

module reply_tx_buffer
    import picc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    reply_if.sink      rep,

    input  logic       tx_req,
    output logic [7:0] tx_data,
    output logic       tx_data_valid,
    output logic       tx_append_crc
);

    // byte 0 is always the one on tx_data
    logic [7:0] tx_buf [tx_buf_len_c];

    // bytes left after the current one
    logic [2:0] remaining;
    // AC alignment, one byte dropped per cycle
    logic [2:0] shift_cnt;
    logic       valid_pending;
    logic       shift_en;

    assign tx_data = tx_buf[0];

    // alignment shift, or the transmitter took a byte and more follow
    assign shift_en = (shift_cnt != 3'd0) ||
                      (tx_req && tx_data_valid && (remaining != 3'd0));

    // ==============================
    // payload
    // ==============================

    always_ff @(posedge clk) begin
        if (shift_en) begin
            for (int i = 0; i < tx_buf_len_c - 1; i++) begin
                tx_buf[i] <= tx_buf[i+1];
            end
        end

        // a new reply wins over any shift
        case (rep.reply)
            reply_atqa: begin
                // low byte first
                tx_buf[0] <= atqa_double_c[7:0];
                tx_buf[1] <= atqa_double_c[15:8];
            end
            reply_sak: begin
                tx_buf[0] <= rep.uid_complete ? sak_complete_c : sak_not_complete_c;
            end
            reply_ac: begin
                tx_buf[0] <= rep.cascade_data.uid[7:0];
                tx_buf[1] <= rep.cascade_data.uid[15:8];
                tx_buf[2] <= rep.cascade_data.uid[23:16];
                tx_buf[3] <= rep.cascade_data.uid[31:24];
                tx_buf[4] <= rep.cascade_data.bcc;
            end
            default: begin
            end
        endcase
    end

    // ==============================
    // control
    // ==============================

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            remaining     <= '0;
            shift_cnt     <= '0;
            valid_pending <= 1'b0;
            tx_data_valid <= 1'b0;
            tx_append_crc <= 1'b0;
        end
        else begin
            if (shift_cnt != 3'd0) begin
                shift_cnt <= shift_cnt - 3'd1;
            end
            else if (valid_pending) begin
                // aligned, first unsent byte now at the front
                valid_pending <= 1'b0;
                tx_data_valid <= 1'b1;
            end

            if (tx_req && tx_data_valid) begin
                if (remaining != 3'd0) begin
                    remaining <= remaining - 3'd1;
                end
                else begin
                    tx_data_valid <= 1'b0;
                end
            end

            case (rep.reply)
                reply_atqa: begin
                    remaining     <= 3'd1;
                    tx_append_crc <= 1'b0;
                    tx_data_valid <= 1'b1;
                end
                reply_sak: begin
                    remaining     <= 3'd0;
                    tx_append_crc <= 1'b1;
                    tx_data_valid <= 1'b1;
                end
                reply_ac: begin
                    // 5 - skip bytes to send, minus the one on tx_data
                    remaining     <= 3'd4 - rep.skip_bytes;
                    shift_cnt     <= rep.skip_bytes;
                    tx_append_crc <= 1'b0;
                    // nothing to drop, go straight out like ATQA
                    if (rep.skip_bytes == 3'd0) begin
                        tx_data_valid <= 1'b1;
                    end
                    else begin
                        valid_pending <= 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- verilog/picc_init_top.sv
// top level of the ISO 14443-3 type A init responder
// frame capture -> card state machine -> reply buffer

`timescale 1ns/1ps

module picc_init_top
    import picc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // deframed receive side, strobes
    input  logic       rx_soc,
    input  logic       rx_eoc,
    input  logic       rx_error,
    input  logic       rx_data_valid,
    input  logic [7:0] rx_data,
    // level, valid at rx_eoc
    input  logic       rx_crc_ok,

    // fixed while out of reset
    input  uid_t       uid,

    // transmit side
    input  logic       tx_req,
    output logic [7:0] tx_data,
    output logic       tx_data_valid,
    output logic       tx_append_crc
);

    rx_frame_if frame_bus ();
    reply_if    reply_bus ();

    rx_frame_buffer u_rx_frame_buffer (
        .clk           (clk),
        .rst_n         (rst_n),
        .rx_soc        (rx_soc),
        .rx_eoc        (rx_eoc),
        .rx_error      (rx_error),
        .rx_data_valid (rx_data_valid),
        .rx_data       (rx_data),
        .frame         (frame_bus.producer)
    );

    picc_state_fsm u_picc_state_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .uid       (uid),
        .rx_crc_ok (rx_crc_ok),
        .frame     (frame_bus.consumer),
        .rep       (reply_bus.source)
    );

    reply_tx_buffer u_reply_tx_buffer (
        .clk           (clk),
        .rst_n         (rst_n),
        .rep           (reply_bus.sink),
        .tx_req        (tx_req),
        .tx_data       (tx_data),
        .tx_data_valid (tx_data_valid),
        .tx_append_crc (tx_append_crc)
    );

endmodule

//--- tests/picc_init_checker.sv
// reply checker for the PICC init testbench
// queues one expected reply per frame, records the byte on tx_data
// at every tx_req and compares the reply once tx_data_valid drops

`timescale 1ns/1ps

module picc_init_checker (
    input  logic        clk,

    // DUT ports being watched
    input  logic        rx_eoc,
    input  logic        tx_req,
    input  logic [7:0]  tx_data,
    input  logic        tx_data_valid,
    input  logic        tx_append_crc,

    // expected reply for the frame being sent, byte 0 in bits 7:0
    input  logic        exp_push,
    input  logic [2:0]  exp_len,
    input  logic [39:0] exp_bytes,
    input  logic        exp_crc,

    output logic        frame_done,
    output int          value_errors,
    output int          protocol_errors
);

    // longest AC alignment is 4 cycles, plenty of margin on top
    localparam int reply_window_c = 16;

    logic [2:0]  len_q  [$];
    logic [39:0] data_q [$];
    logic        crc_q  [$];

    // everything is sampled on the falling edge, inputs and DUT outputs are settled there
    always @(negedge clk) begin
        if (exp_push) begin
            len_q.push_back(exp_len);
            data_q.push_back(exp_bytes);
            crc_q.push_back(exp_crc);
        end
    end

    // ==============================
    // one reply
    // ==============================

    task automatic check_reply();
        logic [2:0]  len;
        logic [39:0] data;
        logic        crc;
        logic [7:0]  got [$];
        logic        seen;
        int          waited;
        int          i;

        len  = len_q.pop_front();
        data = data_q.pop_front();
        crc  = crc_q.pop_front();

        // reply starts 2 cycles after eoc, AC later by its skip count
        waited = 0;
        while (!tx_data_valid && (waited < reply_window_c)) begin
            @(negedge clk);
            waited++;
        end
        seen = tx_data_valid;

        // bytes leave only on a tx_req
        while (tx_data_valid) begin
            if (tx_req) begin
                got.push_back(tx_data);
                if (tx_append_crc !== crc) begin
                    $display("FAIL t=%0t tx_append_crc expected %0b got %0b",
                             $time, crc, tx_append_crc);
                    value_errors++;
                end
            end
            @(negedge clk);
        end

        if (!seen && (len != 3'd0)) begin
            $display("missing reply at %0t, expected %0d bytes but valid never rose",
                     $time, len);
            protocol_errors++;
        end
        else if (seen && (len == 3'd0)) begin
            $display("unexpected reply of %0d bytes at %0t, frame should get no answer",
                     got.size(), $time);
            protocol_errors++;
        end
        else if (seen) begin
            if (got.size() != len) begin
                $display("FAIL t=%0t tx_data byte count expected %0d got %0d",
                         $time, len, got.size());
                value_errors++;
            end
            for (i = 0; (i < got.size()) && (i < len); i++) begin
                if (got[i] !== data[i*8 +: 8]) begin
                    $display("FAIL t=%0t tx_data byte %0d expected %02h got %02h",
                             $time, i, data[i*8 +: 8], got[i]);
                    value_errors++;
                end
            end
        end
    endtask

    // ==============================
    // frame tracking
    // ==============================

    initial begin
        frame_done      = 1'b0;
        value_errors    = 0;
        protocol_errors = 0;
        forever begin
            @(negedge clk);
            frame_done = 1'b0;
            if (rx_eoc === 1'b1) begin
                if (len_q.size() == 0) begin
                    $display("frame ended at %0t with no expected reply queued", $time);
                    protocol_errors++;
                end
                else begin
                    check_reply();
                end
                // tells the stimulus side that the next frame may go
                frame_done = 1'b1;
            end
        end
    end

endmodule

//--- tests/tb_picc_init.sv
// testbench for the ISO 14443-3 type A init responder
// clock and reset, frames and expected replies from the tests file,
// tx_req pacing with random gaps, timeout and closing report

`timescale 1ns/1ps

module tb_picc_init
    import picc_pkg::*;
();

    localparam int max_frames_c       = 64;
    localparam int max_cmd_c          = 8;
    localparam int reset_cycles_c     = 16;
    localparam int cycles_per_frame_c = 60;
    localparam int drive_delay_c      = 10;

    logic        clk;
    logic        rst_n;
    logic        rx_soc;
    logic        rx_eoc;
    logic        rx_error;
    logic        rx_data_valid;
    logic [7:0]  rx_data;
    logic        rx_crc_ok;
    uid_t        uid;
    logic        tx_req;
    logic [7:0]  tx_data;
    logic        tx_data_valid;
    logic        tx_append_crc;

    // towards the checker
    logic        exp_push;
    logic [2:0]  exp_len;
    logic [39:0] exp_bytes;
    logic        exp_crc;
    logic        frame_done;
    int          value_errors;
    int          protocol_errors;

    int          stim_errors;
    int          frame_count;
    int          cycle_cnt;
    int          cycle_limit;
    int          total_errors;
    int          n;
    int          gap;
    int unsigned rand_seed;
    int unsigned rand_val;

    // one entry per frame line
    logic [7:0]  cmd_mem  [max_frames_c][max_cmd_c];
    int          cmd_len  [max_frames_c];
    logic        err_mem  [max_frames_c];
    logic        crc_mem  [max_frames_c];
    logic [2:0]  rep_len  [max_frames_c];
    logic [39:0] rep_mem  [max_frames_c];
    logic        acrc_mem [max_frames_c];

    picc_init_top dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .rx_soc        (rx_soc),
        .rx_eoc        (rx_eoc),
        .rx_error      (rx_error),
        .rx_data_valid (rx_data_valid),
        .rx_data       (rx_data),
        .rx_crc_ok     (rx_crc_ok),
        .uid           (uid),
        .tx_req        (tx_req),
        .tx_data       (tx_data),
        .tx_data_valid (tx_data_valid),
        .tx_append_crc (tx_append_crc)
    );

    picc_init_checker chk (
        .clk             (clk),
        .rx_eoc          (rx_eoc),
        .tx_req          (tx_req),
        .tx_data         (tx_data),
        .tx_data_valid   (tx_data_valid),
        .tx_append_crc   (tx_append_crc),
        .exp_push        (exp_push),
        .exp_len         (exp_len),
        .exp_bytes       (exp_bytes),
        .exp_crc         (exp_crc),
        .frame_done      (frame_done),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors)
    );

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ==============================
    // tests file
    // ==============================

    function automatic logic [31:0] read_hex(input int fd);
        logic [31:0] val;
        int          code;

        code = $fscanf(fd, "%h", val);
        if (code != 1) begin
            $display("malformed frame line in the tests file");
            stim_errors++;
            val = '0;
        end
        return val;
    endfunction

    task automatic read_tests();
        int           fd;
        int           code;
        int           i;
        logic [31:0]  val;
        logic [63:0]  tok;
        logic [1279:0] line;

        fd = $fopen("tests/picc_init_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open the tests file tests/picc_init_tests.txt");
            stim_errors++;
        end
        else begin
            code = $fscanf(fd, "%s", tok);
            while (code == 1) begin
                if (tok == "#") begin
                    code = $fgets(line, fd);
                end
                else if (tok == "U") begin
                    code = $fscanf(fd, "%h", uid);
                end
                else if ((tok == "F") && (frame_count < max_frames_c)) begin
                    // err crc_ok ncmd bytes.. nrep bytes.. append_crc
                    val = read_hex(fd);
                    err_mem[frame_count] = val[0];
                    val = read_hex(fd);
                    crc_mem[frame_count] = val[0];
                    val = read_hex(fd);
                    cmd_len[frame_count] = (val > max_cmd_c) ? max_cmd_c : val;
                    for (i = 0; i < cmd_len[frame_count]; i++) begin
                        val = read_hex(fd);
                        cmd_mem[frame_count][i] = val[7:0];
                    end
                    val = read_hex(fd);
                    rep_len[frame_count] = val[2:0];
                    rep_mem[frame_count] = '0;
                    for (i = 0; i < rep_len[frame_count]; i++) begin
                        val = read_hex(fd);
                        rep_mem[frame_count][i*8 +: 8] = val[7:0];
                    end
                    val = read_hex(fd);
                    acrc_mem[frame_count] = val[0];
                    frame_count++;
                end
                else begin
                    $display("unknown or surplus record in the tests file");
                    stim_errors++;
                    code = $fgets(line, fd);
                end
                code = $fscanf(fd, "%s", tok);
            end
            $fclose(fd);
        end
        if (frame_count == 0) begin
            $display("no frames found in the tests file");
            stim_errors++;
        end
    endtask

    // ==============================
    // frame driver
    // ==============================

    task automatic send_frame(input int idx);
        int i;

        // soc goes alone so the capture clears its count in that cycle
        @(posedge clk);
        #drive_delay_c;
        rx_soc    = 1'b1;
        rx_crc_ok = crc_mem[idx];
        exp_push  = 1'b1;
        exp_len   = rep_len[idx];
        exp_bytes = rep_mem[idx];
        exp_crc   = acrc_mem[idx];
        @(posedge clk);
        #drive_delay_c;
        rx_soc   = 1'b0;
        exp_push = 1'b0;
        for (i = 0; i < cmd_len[idx]; i++) begin
            rx_data_valid = 1'b1;
            rx_data       = cmd_mem[idx][i];
            // error strobe rides on the first byte
            rx_error      = err_mem[idx] && (i == 0);
            @(posedge clk);
            #drive_delay_c;
        end
        rx_data_valid = 1'b0;
        rx_error      = 1'b0;
        rx_eoc        = 1'b1;
        @(posedge clk);
        #drive_delay_c;
        // crc_ok stays put since the FSM reads it one cycle after eoc
        rx_eoc = 1'b0;
    endtask

    // transmitter model that takes a byte a few cycles after valid is seen
    initial begin
        rand_seed = 32'he230;
        rand_val  = $urandom(rand_seed);
        forever begin
            @(negedge clk);
            if (tx_data_valid === 1'b1) begin
                gap      = rand_val % 4;
                rand_val = $urandom;
                repeat (gap) @(posedge clk);
                @(posedge clk);
                #drive_delay_c;
                tx_req = 1'b1;
                @(posedge clk);
                #drive_delay_c;
                tx_req = 1'b0;
            end
        end
    end

    // ==============================
    // main sequence
    // ==============================

    initial begin
        rst_n         = 1'b0;
        rx_soc        = 1'b0;
        rx_eoc        = 1'b0;
        rx_error      = 1'b0;
        rx_data_valid = 1'b0;
        rx_data       = '0;
        rx_crc_ok     = 1'b0;
        uid           = '0;
        tx_req        = 1'b0;
        exp_push      = 1'b0;
        exp_len       = '0;
        exp_bytes     = '0;
        exp_crc       = 1'b0;
        stim_errors   = 0;
        frame_count   = 0;

        read_tests();
        // one extra frame slot covers reset
        cycle_limit = (frame_count + 1) * cycles_per_frame_c;

        repeat (reset_cycles_c) @(posedge clk);
        #drive_delay_c;
        rst_n = 1'b1;

        for (n = 0; n < frame_count; n++) begin
            send_frame(n);
            while (frame_done !== 1'b1) @(posedge clk);
        end
        repeat (4) @(posedge clk);

        total_errors = value_errors + protocol_errors + stim_errors;
        $display("errors: %0d value, %0d protocol, %0d stimulus over %0d frames",
                 value_errors, protocol_errors, stim_errors, frame_count);
        if (total_errors == 0) begin
            $display("Test completed successfully");
        end
        else begin
            $display("Test failed");
        end
        $finish;
    end

    // limit follows from the frame count read above
    initial begin
        cycle_cnt = 0;
        @(posedge clk);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, a frame or its reply never finished", cycle_cnt);
        $display("Test failed");
        $finish;
    end

endmodule

//--- tests/picc_init_tests.txt
# U <uid, 56 bit hex, UID0 in the low byte>
# F <rx_error> <crc_ok> <ncmd> <cmd bytes> <nrep> <reply bytes> <append_crc>
U F6E5D4C3B2A104
# REQA in idle, then REQA in ready drops to idle
F 0 1 1 26 2 44 00 0
F 0 1 1 26 0 0
# WUPA, anticollision level 1 with 0, 2 and 4 known bytes
F 0 1 1 52 2 44 00 0
F 0 1 2 93 20 5 88 04 A1 B2 9F 0
F 0 1 4 93 40 88 04 3 A1 B2 9F 0
F 0 1 6 93 60 88 04 A1 B2 1 9F 0
# mismatching AC, bad CRC SELECT, rx_error and a bit count NVB all go idle
F 0 1 4 93 40 88 05 0 0
F 0 1 1 26 2 44 00 0
F 0 0 7 93 70 88 04 A1 B2 9F 0 0
F 0 1 1 26 2 44 00 0
F 1 1 2 93 20 0 0
F 0 1 1 26 2 44 00 0
F 0 1 2 93 21 0 0
F 0 1 1 26 2 44 00 0
# select level 1, anticollision and select level 2
F 0 1 7 93 70 88 04 A1 B2 9F 1 04 1
F 0 1 2 95 20 5 C3 D4 E5 F6 04 0
F 0 1 5 95 50 C3 D4 E5 2 F6 04 0
F 0 1 7 95 70 C3 D4 E5 F6 04 1 00 1
# HLTA in active, halted card ignores REQA and wakes on WUPA
F 0 1 2 50 00 0 0
F 0 1 1 26 0 0
F 0 1 1 52 2 44 00 0
F 0 1 2 93 20 5 88 04 A1 B2 9F 0

//--- sources.f
verilog/picc_pkg.sv
verilog/rx_frame_if.sv
verilog/reply_if.sv
verilog/rx_frame_buffer.sv
verilog/picc_state_fsm.sv
verilog/reply_tx_buffer.sv
verilog/picc_init_top.sv
tests/picc_init_checker.sv
tests/tb_picc_init.sv

//--- Bender.yml
package:
  name: picc_init

sources:
  # RTL in compile order, package first
  - verilog/picc_pkg.sv
  - verilog/rx_frame_if.sv
  - verilog/reply_if.sv
  - verilog/rx_frame_buffer.sv
  - verilog/picc_state_fsm.sv
  - verilog/reply_tx_buffer.sv
  - verilog/picc_init_top.sv

  # testbench, top module tb_picc_init
  - target: test
    files:
      - tests/picc_init_checker.sv
      - tests/tb_picc_init.sv
